/* include/network_cfg.svh */
// --------------------------------------
// network configuration
// sizes, firing threshold, sink depth and
// the fixed synapse weight table
// --------------------------------------

`ifndef NETWORK_CFG_SVH
`define NETWORK_CFG_SVH

// input charges per host word and neurons in the array
`define NET_NUM_INP 4
`define NET_NUM_OUT 4

// signed widths of one charge and one membrane potential
`define NET_CHARGE_WIDTH 8
`define NET_POT_WIDTH 12

// a potential at or above this fires the neuron
`define NET_THRESHOLD 200

// spike vectors the sink can hold toward the host
`define NET_SINK_DEPTH 2

// signed 4-bit weights, neuron j owns bits [j*16 +: 16]
// input i of that neuron sits in nibble i
`define NET_WEIGHTS 64'h3068_2222_4D2F_1357

`endif

/* logic/network_pkg.sv */
// --------------------------------------
// network types
// opcode, charge, potential and spike
// vector types shared by the datapath
// --------------------------------------

`include "network_cfg.svh"

package network_pkg;

    // opcode field of a host word, top bit of src
    localparam int OPC_WIDTH = 1;

    typedef enum logic [OPC_WIDTH-1:0] {
        NOM = 1'b0,
        CLR = 1'b1
    } opcode_t;

    // one signed input charge
    typedef logic signed [`NET_CHARGE_WIDTH-1:0] charge_t;

    // one signed membrane potential
    typedef logic signed [`NET_POT_WIDTH-1:0] pot_t;

    // fired flag per neuron, bit j is neuron j
    typedef logic [`NET_NUM_OUT-1:0] spikes_t;

    // opcode on top, charge 0 just below it, last charge at bit 0
    localparam int SRC_WIDTH = OPC_WIDTH + `NET_NUM_INP * `NET_CHARGE_WIDTH;

    // width of one entry in the weight table
    localparam int WEIGHT_WIDTH = 4;

    // saturation limits of a potential
    localparam pot_t POT_MAX = {1'b0, {(`NET_POT_WIDTH - 1){1'b1}}};
    localparam pot_t POT_MIN = {1'b1, {(`NET_POT_WIDTH - 1){1'b0}}};

endpackage

/* logic/network_step_if.sv */
// --------------------------------------
// network step interface
// one decoded host word from source to
// core, and the core result back out
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

interface network_step_if import network_pkg::*; ();

    // accepted host word this cycle
    logic    step;
    // word is a clear, not an integration
    logic    clear;
    // charges of the word
    charge_t inp [`NET_NUM_INP];
    // registered result of the last NOM step
    spikes_t fired;
    // one-cycle pulse, fired holds a new result
    logic    out_valid;

    // decoder side
    modport source (output clear, output inp);

    // neuron array
    modport core (input step, input clear, input inp, output fired, output out_valid);

    // step issue, also the read view of the result for the sink
    modport ctrl (output step, input clear, input out_valid, input fired);

endinterface

/* logic/network_source.sv */
// --------------------------------------
// network source decoder
// splits a host word into its opcode and
// the array of signed input charges
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

module network_source import network_pkg::*; (
    // raw host word
    input logic [SRC_WIDTH-1:0] src,
    // decoded view toward core and control
    network_step_if.source      step
);

    // opcode sits in the top bit(s) of the word
    opcode_t opcode;

    assign opcode = opcode_t'(src[SRC_WIDTH-1 -: OPC_WIDTH]);

    // only CLR words wipe the array, NOM words integrate
    assign step.clear = (opcode == CLR);

    // charge 0 directly below the opcode, then downward
    // each slice keeps its sign through charge_t
    always_comb begin : slice_charges
        for (int i = 0; i < `NET_NUM_INP; i++) begin
            step.inp[i] = charge_t'(
                src[SRC_WIDTH - OPC_WIDTH - i * `NET_CHARGE_WIDTH - 1 -: `NET_CHARGE_WIDTH]
            );
        end
    end

endmodule

/* logic/network_core.sv */
// --------------------------------------
// network core
// integrate-and-fire neuron array with
// saturating potentials and a registered
// spike vector per NOM step
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

module network_core import network_pkg::*; (
    input logic          clk,
    input logic          arstn,
    network_step_if.core step
);

    // wide enough for a potential plus every weighted charge
    localparam int ACC_WIDTH = `NET_POT_WIDTH + `NET_CHARGE_WIDTH + WEIGHT_WIDTH;

    localparam int TABLE_WIDTH = `NET_NUM_INP * `NET_NUM_OUT * WEIGHT_WIDTH;

    // fixed synapse table, one nibble per input and neuron
    localparam logic [TABLE_WIDTH-1:0] WEIGHTS = `NET_WEIGHTS;

    localparam pot_t THRESHOLD = pot_t'(`NET_THRESHOLD);

    // stored membrane potentials
    pot_t    pot_q [`NET_NUM_OUT];
    // potentials after this step, before the clear check
    pot_t    pot_d [`NET_NUM_OUT];
    // neurons that fire on this step
    spikes_t fire_d;

    // next state of every neuron
    always_comb begin : integrate
        logic signed [WEIGHT_WIDTH-1:0] w;
        logic signed [ACC_WIDTH-1:0]    w_ext;
        logic signed [ACC_WIDTH-1:0]    c_ext;
        logic signed [ACC_WIDTH-1:0]    acc;
        pot_t                           sat;

        fire_d = '0;
        for (int j = 0; j < `NET_NUM_OUT; j++) begin
            // start from the present potential, sign extended
            acc = pot_q[j];
            for (int i = 0; i < `NET_NUM_INP; i++) begin
                w     = WEIGHTS[(j * `NET_NUM_INP + i) * WEIGHT_WIDTH +: WEIGHT_WIDTH];
                w_ext = w;
                c_ext = step.inp[i];
                acc   = acc + w_ext * c_ext;
            end

            // clamp to the range of pot_t
            if (acc > POT_MAX) begin
                sat = POT_MAX;
            end else if (acc < POT_MIN) begin
                sat = POT_MIN;
            end else begin
                sat = pot_t'(acc);
            end

            // fire and restart from zero, else keep the clamped sum
            if (sat >= THRESHOLD) begin
                fire_d[j] = 1'b1;
                pot_d[j]  = '0;
            end else begin
                pot_d[j]  = sat;
            end
        end
    end

    // potentials and result strobe
    always_ff @(posedge clk) begin : state_regs
        if (!arstn) begin
            for (int j = 0; j < `NET_NUM_OUT; j++) begin
                pot_q[j] <= '0;
            end
            step.out_valid <= 1'b0;
        end else begin
            // a result only follows an accepted NOM word
            step.out_valid <= step.step && !step.clear;
            if (step.step) begin
                for (int j = 0; j < `NET_NUM_OUT; j++) begin
                    // CLR wipes everything, NOM takes the new value
                    pot_q[j] <= step.clear ? '0 : pot_d[j];
                end
            end
        end
    end

    // spike vector, only meaningful while out_valid is high
    always_ff @(posedge clk) begin : result_reg
        if (step.step && !step.clear) begin
            step.fired <= fire_d;
        end
    end

endmodule

/* logic/network_control.sv */
// --------------------------------------
// network control
// host source handshake, step issue and
// the credit count of free sink entries
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

module network_control import network_pkg::*; (
    input  logic          clk,
    input  logic          arstn,
    // host source handshake
    input  logic          src_valid,
    output logic          src_ready,
    // one pulse per entry popped from the sink
    input  logic          credit_return,
    network_step_if.ctrl  ctrl
);

    // counts 0 .. NET_SINK_DEPTH
    localparam int CRED_WIDTH = $clog2(`NET_SINK_DEPTH + 1);

    localparam logic [CRED_WIDTH-1:0] CRED_INIT = CRED_WIDTH'(`NET_SINK_DEPTH);

    // free sink entries not yet claimed by a NOM word
    logic [CRED_WIDTH-1:0] credits;
    // low during reset and its first clock after
    logic                  run_q;
    // NOM step that claims an entry this cycle
    logic                  take;

    // ready only with room for the result this word may produce
    // CLR waits on a credit too, so one rule covers both
    assign src_ready = run_q && (credits != '0);

    // step is the source transfer itself, no extra latency
    assign ctrl.step = src_valid && src_ready;

    assign take = ctrl.step && !ctrl.clear;

    always_ff @(posedge clk) begin : credit_regs
        if (!arstn) begin
            run_q   <= 1'b0;
            credits <= CRED_INIT;
        end else begin
            run_q <= 1'b1;
            // claim and return in the same cycle cancel out
            case ({take, credit_return})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    credits <= credits + 1'b1;
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

endmodule

/* logic/network_sink.sv */
// --------------------------------------
// network sink
// queue of spike vectors toward the host,
// returns one credit on every pop
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

module network_sink import network_pkg::*; (
    input  logic          clk,
    input  logic          arstn,
    // result of the core, read side only
    network_step_if.ctrl  res,
    // host sink handshake
    output logic          snk_valid,
    input  logic          snk_ready,
    output spikes_t       snk,
    // frees one credit in control
    output logic          credit_return
);

    localparam int DEPTH     = `NET_SINK_DEPTH;
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    localparam logic [PTR_WIDTH-1:0] PTR_LAST = PTR_WIDTH'(DEPTH - 1);

    spikes_t               mem [DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    // entries held, credits keep it at or below DEPTH
    logic [CNT_WIDTH-1:0]  count;
    logic                  push;
    logic                  pop;

    assign push = res.out_valid;
    assign pop  = snk_valid && snk_ready;

    assign snk_valid     = (count != '0);
    assign snk           = mem[rd_ptr];
    assign credit_return = pop;

    // storage, written only into a free slot
    always_ff @(posedge clk) begin : queue_mem
        if (push) begin
            mem[wr_ptr] <= res.fired;
        end
    end

    always_ff @(posedge clk) begin : queue_ptrs
        if (!arstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // count moves only when exactly one side acts
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* logic/network_top.sv */
// --------------------------------------
// network top level
// host source and sink ports around the
// decoder, neuron core, control and sink
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

module network_top import network_pkg::*; (
    input  logic                 clk,
    input  logic                 arstn,
    // host words in
    input  logic                 src_valid,
    output logic                 src_ready,
    input  logic [SRC_WIDTH-1:0] src,
    // spike vectors out
    output logic                 snk_valid,
    input  logic                 snk_ready,
    output spikes_t              snk
);

    // decoded step and core result
    network_step_if step_if ();

    // sink pop back to the credit counter
    logic credit_return;

    network_source u_source (
        .src  (src),
        .step (step_if.source)
    );

    network_control u_control (
        .clk           (clk),
        .arstn         (arstn),
        .src_valid     (src_valid),
        .src_ready     (src_ready),
        .credit_return (credit_return),
        .ctrl          (step_if.ctrl)
    );

    network_core u_core (
        .clk   (clk),
        .arstn (arstn),
        .step  (step_if.core)
    );

    network_sink u_sink (
        .clk           (clk),
        .arstn         (arstn),
        .res           (step_if.ctrl),
        .snk_valid     (snk_valid),
        .snk_ready     (snk_ready),
        .snk           (snk),
        .credit_return (credit_return)
    );

endmodule

/* tests/network_props.sv */
// --------------------------------------
// network handshake properties
// reset levels, sink hold and the credit
// bound on accepted NOM words
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

module network_props import network_pkg::*; (
    input logic                 clk,
    input logic                 arstn,
    input logic                 src_valid,
    input logic                 src_ready,
    input logic [SRC_WIDTH-1:0] src,
    input logic                 snk_valid,
    input logic                 snk_ready,
    input spikes_t              snk
);

    // failed property count, the testbench watches it
    int unsigned fails = 0;
    // NOM words accepted and not yet popped
    int          outstanding;
    // high from the first reset edge on
    logic        in_reset_q;
    logic        nom_accept;
    logic        pop;

    assign nom_accept = src_valid && src_ready && (opcode_t'(src[SRC_WIDTH-1]) == NOM);
    assign pop        = snk_valid && snk_ready;

    always_ff @(posedge clk) begin : track_regs
        in_reset_q <= !arstn;
        if (!arstn) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(nom_accept) - int'(pop);
        end
    end

    // both outputs low once reset has been seen at an edge
    reset_quiet : assert property (
        @(posedge clk) !arstn && in_reset_q |-> !src_ready && !snk_valid
    ) else begin
        fails++;
        $error("src_ready or snk_valid high during reset");
    end

    // an offered vector holds until the host takes it
    sink_hold : assert property (
        @(posedge clk) disable iff (!arstn) snk_valid && !snk_ready |=> snk_valid && $stable(snk)
    ) else begin
        fails++;
        $error("snk dropped or changed before the host took it");
    end

    // every sink entry claimed, so no further NOM word
    credit_bound : assert property (
        @(posedge clk) disable iff (!arstn) outstanding >= `NET_SINK_DEPTH |-> !nom_accept
    ) else begin
        fails++;
        $error("NOM word accepted with no free sink entry");
    end

endmodule

bind network_top network_props u_props (
    .clk       (clk),       .arstn     (arstn),
    .src_valid (src_valid), .src_ready (src_ready), .src (src),
    .snk_valid (snk_valid), .snk_ready (snk_ready), .snk (snk)
);

/* tests/network_tb.sv */
// --------------------------------------
// network testbench
// drives host words, models the neuron
// array and checks every popped vector
// --------------------------------------

`timescale 1ns/100ps

`include "network_cfg.svh"

module network_tb import network_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    localparam int RAND_WORDS   = 16;
    // all words sent by the sequence in main_flow
    localparam int NUM_WORDS    = 25 + `NET_SINK_DEPTH + RAND_WORDS;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_WORDS * (`NET_SINK_DEPTH + 20);
    localparam int POT_HI = (1 << (`NET_POT_WIDTH - 1)) - 1;
    localparam int POT_LO = -(1 << (`NET_POT_WIDTH - 1));
    localparam int ROW_BITS   = `NET_NUM_INP * WEIGHT_WIDTH;
    localparam int TABLE_BITS = `NET_NUM_OUT * ROW_BITS;
    localparam logic [TABLE_BITS-1:0] WEIGHTS = `NET_WEIGHTS;
    // snk_ready policies
    localparam int READY_ALWAYS = 0;
    localparam int READY_HOLD   = 1;
    localparam int READY_RANDOM = 2;

    logic                 clk;
    logic                 arstn;
    logic                 src_valid;
    logic                 src_ready;
    logic [SRC_WIDTH-1:0] src;
    logic                 snk_valid;
    logic                 snk_ready;
    spikes_t              snk;

    // reference potentials, next charges and expected vectors
    int          pot [`NET_NUM_OUT];
    charge_t     chg [`NET_NUM_INP];
    spikes_t     exp_q [$];
    int          ready_mode = READY_ALWAYS;
    logic [31:0] rng_state  = 32'hd724;

    network_top uut (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src       (src),
        .snk_valid (snk_valid),
        .snk_ready (snk_ready),
        .snk       (snk)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // row of neuron j first, then nibble i inside that row
    function automatic int weight(input int j, input int i);
        logic [ROW_BITS-1:0]            row;
        logic signed [WEIGHT_WIDTH-1:0] w;
        row = WEIGHTS[j * ROW_BITS +: ROW_BITS];
        w   = row[i * WEIGHT_WIDTH +: WEIGHT_WIDTH];
        return int'(w);
    endfunction

    task automatic set_charges(input int v);
        for (int i = 0; i < `NET_NUM_INP; i++) begin
            chg[i] = charge_t'(v);
        end
    endtask

    task automatic random_charges();
        logic [31:0] r;
        for (int i = 0; i < `NET_NUM_INP; i++) begin
            r      = next_rand();
            chg[i] = charge_t'(r[23:16]);
        end
    endtask

    // integrate, clamp, fire at threshold, restart from zero
    task automatic apply_model(input opcode_t op);
        spikes_t fired;
        int      sum;
        fired = '0;
        for (int j = 0; j < `NET_NUM_OUT; j++) begin
            sum = pot[j];
            for (int i = 0; i < `NET_NUM_INP; i++) begin
                sum += weight(j, i) * int'(chg[i]);
            end
            if (sum > POT_HI) begin
                sum = POT_HI;
            end else if (sum < POT_LO) begin
                sum = POT_LO;
            end
            if (op == CLR) begin
                pot[j] = 0;
            end else if (sum >= `NET_THRESHOLD) begin
                fired[j] = 1'b1;
                pot[j]   = 0;
            end else begin
                pot[j] = sum;
            end
        end
        if (op == NOM) begin
            exp_q.push_back(fired);
        end
    endtask

    // entered just after a rising edge and returns at the transfer edge
    task automatic send_word(input opcode_t op);
        logic [SRC_WIDTH-1:0] word;
        logic                 hit;
        word            = '0;
        word[SRC_WIDTH-1] = op;
        for (int i = 0; i < `NET_NUM_INP; i++) begin
            word[SRC_WIDTH - 2 - i * `NET_CHARGE_WIDTH -: `NET_CHARGE_WIDTH] = chg[i];
        end
        #2;
        src_valid = 1'b1;
        src       = word;
        hit       = 1'b0;
        while (!hit) begin
            @(negedge clk);
            hit = src_ready;
            @(posedge clk);
        end
        apply_model(op);
    endtask

    task automatic release_src();
        #2;
        src_valid = 1'b0;
        @(posedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
    endtask

    // host sink side sets ready after the edge and checks mid-cycle
    initial begin : sink_side
        logic [31:0] r;
        spikes_t     expected;
        forever begin
            @(posedge clk);
            #2;
            if (ready_mode == READY_RANDOM) begin
                r         = next_rand();
                snk_ready = r[20];
            end else begin
                snk_ready = (ready_mode == READY_ALWAYS);
            end
            @(negedge clk);
            if (snk_valid) begin
                assert (exp_q.size() != 0)
                    else abort_run("sink offered a vector that no NOM word produced");
                if (snk_ready) begin
                    expected = exp_q.pop_front();
                    assert (snk == expected)
                        else abort_run($sformatf("MISMATCH snk got %h expected %h", snk, expected));
                end
            end
        end
    end

    initial begin : props_watch
        forever begin
            @(negedge clk);
            if (uut.u_props.fails != 0) begin
                abort_run("a bound handshake or credit property failed");
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin : main_flow
        logic [31:0] r;
        src_valid = 1'b0;
        src       = '0;
        snk_ready = 1'b0;
        arstn     = 1'b0;
        set_charges(0);
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arstn = 1'b1;

        // ready comes up while nothing is offered yet
        while (!src_ready) @(negedge clk);
        assert (!snk_valid) else abort_run("sink valid high before any NOM word");
        @(posedge clk);

        // one strong word
        send_word(CLR);
        set_charges(100);
        send_word(NOM);
        // small words build up across several steps
        send_word(CLR);
        set_charges(5);
        repeat (8) send_word(NOM);
        // clear in the middle drops the charge
        send_word(CLR);
        repeat (2) send_word(NOM);
        send_word(CLR);
        repeat (2) send_word(NOM);
        // drive to the low limit and climb back
        send_word(CLR);
        set_charges(-128);
        repeat (3) send_word(NOM);
        set_charges(127);
        repeat (3) send_word(NOM);

        // fill the sink with the host stalled
        release_src();
        drain();
        ready_mode = READY_HOLD;
        send_word(CLR);
        repeat (`NET_SINK_DEPTH) begin
            random_charges();
            send_word(NOM);
        end
        release_src();
        repeat (3) begin
            @(negedge clk);
            assert (!src_ready) else abort_run("source still ready with every sink entry taken");
        end

        // random pops release the backlog and the rest
        @(posedge clk);
        ready_mode = READY_RANDOM;
        repeat (RAND_WORDS) begin
            r = next_rand();
            random_charges();
            send_word((r[31:29] == 3'd0) ? CLR : NOM);
        end
        release_src();
        drain();
        @(negedge clk);

        if (uut.u_props.fails != 0) begin
            abort_run("a bound handshake or credit property failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* network_top.f */
+incdir+include
logic/network_pkg.sv
logic/network_step_if.sv
logic/network_source.sv
logic/network_core.sv
logic/network_control.sv
logic/network_sink.sv
logic/network_top.sv
tests/network_props.sv
tests/network_tb.sv

/* Makefile */
# Verilator build and run of the network testbench

VERILATOR ?= verilator
TOP       ?= network_tb
FILELIST  ?= network_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
FAIL_MSG  ?= >>> FAIL
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BINARY)
	-$(BINARY) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "test failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "test did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
